// ==== design/mbx_defs.svh ====
`ifndef MBX_DEFS_SVH
`define MBX_DEFS_SVH

// Memory buffer geometry
`define MB_WORDS 4
`define MB_IDX_W 2

// One memory word without its parity bit
`define WORD_W 36

// One request bit per buffer slot
`define MB_MASK_W `MB_WORDS

`endif

// ==== design/mbxPkg.sv ====
`default_nettype none
`include "mbx_defs.svh"

package mbxPkg;

  typedef logic [`WORD_W-1:0] wordT;
  typedef logic [`MB_IDX_W-1:0] wordIdxT;
  typedef logic [`MB_MASK_W-1:0] wordMaskT;

  // Word n of a writeback sits at bits [n*WORD_W +: WORD_W]
  typedef logic [`MB_WORDS*`WORD_W-1:0] wordBlockT;

  typedef struct packed {
    logic    ld;
    wordIdxT idx;
    wordT    data;
  } mbLoadT;

  typedef struct packed {
    wordIdxT idx;
    wordT    data;
    logic    par;
  } memWrT;

  // All slots side by side, slot n at index n
  typedef memWrT [`MB_WORDS-1:0] slotWordsT;

  typedef enum logic [1:0] {
    seqIdle,
    seqCache,
    seqCore
  } seqStateT;

  // Priority encoder, lowest set bit wins
  function automatic wordIdxT lowestSet(wordMaskT m);
    wordIdxT idx;
    idx = '0;
    for (int n = `MB_WORDS - 1; n >= 0; n--) begin
      if (m[n]) begin
        idx = wordIdxT'(n);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

// ==== design/cacheToMbSeq.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mbx_defs.svh"

module cacheToMbSeq (
  input  logic              clk,
  input  logic              arstN,
  input  logic              wbStart,
  input  logic              coreWr,
  input  mbxPkg::wordMaskT  wbMask,
  input  mbxPkg::wordBlockT wbData,
  input  mbxPkg::wordIdxT   coreAdr,
  input  mbxPkg::wordT      coreData,
  input  mbxPkg::wordMaskT  pending,
  output logic              busy,
  output mbxPkg::mbLoadT    load
);
  import mbxPkg::*;

  seqStateT  state;
  wordMaskT  maskQ;
  wordMaskT  maskNext;
  wordBlockT blockQ;
  wordIdxT   coreIdxQ;
  wordT      coreDataQ;

  wordIdxT   curIdx;
  wordT      curData;
  wordMaskT  curBit;
  logic      loadGo;

  //////////////////////////////
  // Sequence control
  //////////////////////////////

  // A writeback start always beats a core write, even when its mask is empty
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= seqIdle;
      maskQ <= '0;
    end else begin
      case (state)
        seqIdle: begin
          if (wbStart) begin
            if (wbMask != '0) begin
              state <= seqCache;
              maskQ <= wbMask;
            end
          end else if (coreWr) begin
            state <= seqCore;
          end
        end
        seqCache: begin
          if (loadGo) begin
            maskQ <= maskNext;
            if (maskNext == '0) begin
              state <= seqIdle;
            end
          end
        end
        seqCore: begin
          if (loadGo) begin
            state <= seqIdle;
          end
        end
        default: begin
          state <= seqIdle;
        end
      endcase
    end
  end

  // Source words are only sampled while no sequence runs
  always_ff @(posedge clk) begin
    if (state == seqIdle) begin
      blockQ    <= wbData;
      coreIdxQ  <= coreAdr;
      coreDataQ <= coreData;
    end
  end

  //////////////////////////////
  // Word select and load
  //////////////////////////////

  always_comb begin
    if (state == seqCore) begin
      curIdx  = coreIdxQ;
      curData = coreDataQ;
    end else begin
      curIdx  = lowestSet(maskQ);
      curData = blockQ[curIdx*`WORD_W +: `WORD_W];
    end
    curBit   = wordMaskT'(1) << curIdx;
    maskNext = maskQ & ~curBit;
  end

  // Stall while the target slot still waits for memory
  assign loadGo = (state != seqIdle) && !pending[curIdx];

  always_comb begin
    load.ld   = loadGo;
    load.idx  = curIdx;
    load.data = curData;
  end

  assign busy = (state != seqIdle);

endmodule

`default_nettype wire

// ==== design/memBuffer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mbx_defs.svh"

module memBuffer (
  input  logic              clk,
  input  logic              arstN,
  input  mbxPkg::mbLoadT    load,
  input  logic              grantEn,
  input  mbxPkg::wordIdxT   grantIdx,
  output mbxPkg::wordMaskT  pending,
  output mbxPkg::slotWordsT slotWords
);
  import mbxPkg::*;

  logic parIn;

  // Even parity over the incoming word
  assign parIn = ^load.data;

  //////////////////////////////
  // Word slots
  //////////////////////////////

  for (genvar n = 0; n < `MB_WORDS; n++) begin : gSlot
    logic hit;
    logic clr;
    logic reqQ;
    wordT dataQ;
    logic parQ;

    assign hit = load.ld && (load.idx == wordIdxT'(n));
    assign clr = grantEn && (grantIdx == wordIdxT'(n));

    // Set by a load, cleared by the memory grant
    always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
        reqQ <= 1'b0;
      end else if (hit) begin
        reqQ <= 1'b1;
      end else if (clr) begin
        reqQ <= 1'b0;
      end
    end

    always_ff @(posedge clk) begin
      if (hit) begin
        dataQ <= load.data;
        parQ  <= parIn;
      end
    end

    assign pending[n] = reqQ;

    assign slotWords[n].idx  = wordIdxT'(n);
    assign slotWords[n].data = dataQ;
    assign slotWords[n].par  = parQ;
  end

endmodule

`default_nettype wire

// ==== design/mbWriteArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mbWriteArbiter (
  input  logic              clk,
  input  logic              arstN,
  input  mbxPkg::wordMaskT  pending,
  input  mbxPkg::slotWordsT slotWords,
  input  logic              memAck,
  output logic              memWrReq,
  output mbxPkg::memWrT     memWr,
  output logic              grantEn,
  output mbxPkg::wordIdxT   grantIdx
);
  import mbxPkg::*;

  wordIdxT selIdx;
  logic    anyPend;
  memWrT   holdQ;

  //////////////////////////////
  // Slot select
  //////////////////////////////

  assign selIdx  = lowestSet(pending);
  assign anyPend = |pending;

  // Request level, dropped the cycle after the acknowledge
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memWrReq <= 1'b0;
    end else if (memWrReq) begin
      if (memAck) begin
        memWrReq <= 1'b0;
      end
    end else if (anyPend) begin
      memWrReq <= 1'b1;
    end
  end

  // Selection tracks the buffer while idle and freezes under a request
  always_ff @(posedge clk) begin
    if (!memWrReq) begin
      holdQ <= slotWords[selIdx];
    end
  end

  assign memWr = holdQ;

  //////////////////////////////
  // Grant back to the buffer
  //////////////////////////////

  assign grantEn  = memWrReq && memAck;
  assign grantIdx = holdQ.idx;

endmodule

`default_nettype wire

// ==== design/mbxTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module mbxTop (
  input  logic              clk,
  input  logic              arstN,
  input  logic              wbStart,
  input  mbxPkg::wordMaskT  wbMask,
  input  mbxPkg::wordBlockT wbData,
  input  logic              coreWr,
  input  mbxPkg::wordIdxT   coreAdr,
  input  mbxPkg::wordT      coreData,
  input  logic              memAck,
  output logic              busy,
  output logic              memWrReq,
  output mbxPkg::memWrT     memWr
);
  import mbxPkg::*;

  mbLoadT    load;
  wordMaskT  pending;
  slotWordsT slotWords;
  logic      grantEn;
  wordIdxT   grantIdx;

  // Producer side
  cacheToMbSeq seq0 (
    .clk      (clk),
    .arstN    (arstN),
    .wbStart  (wbStart),
    .coreWr   (coreWr),
    .wbMask   (wbMask),
    .wbData   (wbData),
    .coreAdr  (coreAdr),
    .coreData (coreData),
    .pending  (pending),
    .busy     (busy),
    .load     (load)
  );

  memBuffer mb0 (
    .clk       (clk),
    .arstN     (arstN),
    .load      (load),
    .grantEn   (grantEn),
    .grantIdx  (grantIdx),
    .pending   (pending),
    .slotWords (slotWords)
  );

  // Memory side
  mbWriteArbiter arb0 (
    .clk       (clk),
    .arstN     (arstN),
    .pending   (pending),
    .slotWords (slotWords),
    .memAck    (memAck),
    .memWrReq  (memWrReq),
    .memWr     (memWr),
    .grantEn   (grantEn),
    .grantIdx  (grantIdx)
  );

endmodule

`default_nettype wire

// ==== tests/tbClock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbClock (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for 8 rising edges
  initial begin
    arstN = 1'b0;
    repeat (8) @(posedge clk);
    arstN <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/mbx_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module mbx_props (
  input logic              clk,
  input logic              arstN,
  input logic              busy,
  input logic              memWrReq,
  input logic              memAck,
  input mbxPkg::memWrT     memWr,
  input mbxPkg::mbLoadT    load,
  input mbxPkg::wordMaskT  pending
);
  import mbxPkg::*;

  //////////////////////////////
  // Memory side
  //////////////////////////////

  // Request and word hold until memory takes them
  property reqHeld;
    @(posedge clk) disable iff (!arstN)
      (memWrReq && !memAck) |=> (memWrReq && $stable(memWr));
  endproperty

  reqHeldA: assert property (reqHeld)
    else $error("memWrReq or memWr changed before memAck");

  //////////////////////////////
  // Buffer side
  //////////////////////////////

  property loadFreeSlot;
    @(posedge clk) disable iff (!arstN)
      load.ld |-> !pending[load.idx];
  endproperty

  loadFreeSlotA: assert property (loadFreeSlot)
    else $error("load into slot %0d while its request is pending", load.idx);

  // First cycle out of reset
  property resetQuiet;
    @(posedge clk) $rose(arstN) |-> (!busy && !memWrReq);
  endproperty

  resetQuietA: assert property (resetQuiet)
    else $error("busy or memWrReq high right after reset");

endmodule

bind mbxTop mbx_props props0 (
  .clk      (clk),
  .arstN    (arstN),
  .busy     (busy),
  .memWrReq (memWrReq),
  .memAck   (memAck),
  .memWr    (memWr),
  .load     (load),
  .pending  (pending)
);

`default_nettype wire

// ==== tests/mbxTb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mbx_defs.svh"

module mbxTb;
  import mbxPkg::*;

  localparam int TestCount = 5;
  localparam int WatchdogNs = TestCount * 200 * 10 + 8 * 10;
  localparam int DoneLimit = 600;

  logic      clk;
  logic      arstN;
  logic      wbStart;
  wordMaskT  wbMask;
  wordBlockT wbData;
  logic      coreWr;
  wordIdxT   coreAdr;
  wordT      coreData;
  logic      memAck;
  logic      busy;
  logic      memWrReq;
  memWrT     memWr;

  integer    seed = 32'hc3ec_4d84;
  int        ackMaxDelay = 5;
  int        checkCount = 0;
  int        valueErrs = 0;
  int        otherErrs = 0;
  int        outstanding = 0;
  // Expected writes in start order
  // The first entry for a slot is its next write
  memWrT     expQ[$];
  wordIdxT   writeLog[$];

  tbClock clk0 (.clk(clk), .arstN(arstN));

  mbxTop dut0 (
    .clk      (clk),
    .arstN    (arstN),
    .wbStart  (wbStart),
    .wbMask   (wbMask),
    .wbData   (wbData),
    .coreWr   (coreWr),
    .coreAdr  (coreAdr),
    .coreData (coreData),
    .memAck   (memAck),
    .busy     (busy),
    .memWrReq (memWrReq),
    .memWr    (memWr)
  );

  //////////////////////////////
  // Reference and helpers
  //////////////////////////////

  // Even parity computed one bit at a time
  function automatic logic refParity(wordT w);
    logic p;
    p = 1'b0;
    for (int b = 0; b < `WORD_W; b++) begin
      p = p ^ w[b];
    end
    return p;
  endfunction

  function automatic int randBelow(int n);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % n;
  endfunction

  function automatic wordBlockT randBlock();
    wordBlockT b;
    logic [63:0] r;
    for (int n = 0; n < `MB_WORDS; n++) begin
      r = {$random(seed), $random(seed)};
      b[n*`WORD_W +: `WORD_W] = r[`WORD_W-1:0];
    end
    return b;
  endfunction

  function automatic wordT randWord();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[`WORD_W-1:0];
  endfunction

  function automatic int lowestBit(wordMaskT m);
    int pos;
    pos = -1;
    for (int n = 0; n < `MB_WORDS; n++) begin
      if (m[n] && pos < 0) begin
        pos = n;
      end
    end
    return pos;
  endfunction

  task automatic checkWord(string name, wordT exp, wordT act);
    checkCount++;
    if (act !== exp) begin
      valueErrs++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkIdx(string name, wordIdxT exp, wordIdxT act);
    checkCount++;
    if (act !== exp) begin
      valueErrs++;
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic checkParity(string name, logic exp, logic act);
    checkCount++;
    if (act !== exp) begin
      valueErrs++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic checkBit(string name, logic exp, logic act);
    checkCount++;
    if (act !== exp) begin
      valueErrs++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic reportProblem(string msg);
    otherErrs++;
    $display("ERROR %s", msg);
  endtask

  task automatic checkWriteCount(string name, int exp);
    if (writeLog.size() != exp) begin
      reportProblem($sformatf("%s gave %0d memory writes instead of %0d",
                              name, writeLog.size(), exp));
    end
  endtask

  //////////////////////////////
  // Memory responder and scoreboard
  //////////////////////////////

  initial begin : memResponder
    int delay;
    memAck <= 1'b0;
    forever begin
      @(posedge clk);
      if (arstN && memWrReq) begin
        delay = randBelow(ackMaxDelay + 1);
        repeat (delay) @(posedge clk);
        memAck <= 1'b1;
        @(posedge clk);
        memAck <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin : scoreboard
    int    hit;
    memWrT e;
    if (arstN) begin
      if (memWrReq && memAck) begin
        hit = -1;
        for (int i = 0; i < expQ.size(); i++) begin
          if (hit < 0 && expQ[i].idx == memWr.idx) begin
            hit = i;
          end
        end
        if (hit < 0) begin
          reportProblem($sformatf("memory write to slot %0d with no word expected", memWr.idx));
        end else begin
          e = expQ[hit];
          expQ.delete(hit);
          checkWord($sformatf("slot %0d data", e.idx), e.data, memWr.data);
          checkParity($sformatf("slot %0d parity", e.idx), e.par, memWr.par);
        end
        writeLog.push_back(memWr.idx);
      end
      // Words accepted but not yet loaded keep the sequencer busy
      if (outstanding > 0) begin
        checkBit("busy while loads remain", 1'b1, busy);
      end
      if (dut0.load.ld) begin
        outstanding--;
      end
      if (!busy && wbStart) begin
        for (int n = 0; n < `MB_WORDS; n++) begin
          if (wbMask[n]) begin
            e.idx  = wordIdxT'(n);
            e.data = wbData[n*`WORD_W +: `WORD_W];
            e.par  = refParity(e.data);
            expQ.push_back(e);
            outstanding++;
          end
        end
      end else if (!busy && coreWr) begin
        e.idx  = coreAdr;
        e.data = coreData;
        e.par  = refParity(coreData);
        expQ.push_back(e);
        outstanding++;
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic waitNotBusy();
    @(posedge clk);
    while (busy) begin
      @(posedge clk);
    end
  endtask

  task automatic startWriteback(wordMaskT m, wordBlockT d);
    waitNotBusy();
    wbStart <= 1'b1;
    wbMask  <= m;
    wbData  <= d;
    @(posedge clk);
    wbStart <= 1'b0;
  endtask

  task automatic startCoreWrite(wordIdxT a, wordT d);
    waitNotBusy();
    coreWr   <= 1'b1;
    coreAdr  <= a;
    coreData <= d;
    @(posedge clk);
    coreWr <= 1'b0;
  endtask

  task automatic waitDone(string name);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while ((busy || memWrReq || expQ.size() != 0) && cycles < DoneLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (cycles >= DoneLimit) begin
      reportProblem($sformatf("%s did not finish within %0d cycles", name, DoneLimit));
    end
  endtask

  initial begin : stimulus
    wordMaskT m;
    wordIdxT  adr;
    wordT     dat;
    wbStart  <= 1'b0;
    wbMask   <= '0;
    wbData   <= '0;
    coreWr   <= 1'b0;
    coreAdr  <= '0;
    coreData <= '0;
    @(posedge arstN);
    @(posedge clk);
    checkBit("reset busy", 1'b0, busy);
    checkBit("reset memWrReq", 1'b0, memWrReq);

    // Full writeback
    writeLog.delete();
    startWriteback('1, randBlock());
    waitDone("full writeback");
    checkWriteCount("full writeback", `MB_WORDS);

    // Sparse writeback with a mask neither empty nor full
    writeLog.delete();
    m = wordMaskT'(randBelow(14) + 1);
    startWriteback(m, randBlock());
    waitDone("sparse writeback");
    checkWriteCount("sparse writeback", $countones(m));
    if (writeLog.size() > 0) begin
      checkIdx("sparse first write", wordIdxT'(lowestBit(m)), writeLog[0]);
    end
    foreach (writeLog[i]) begin
      if (!m[writeLog[i]]) begin
        reportProblem($sformatf("sparse writeback wrote unmasked slot %0d", writeLog[i]));
      end
    end

    // Core write followed by starts that arrive while busy
    writeLog.delete();
    adr = wordIdxT'(randBelow(`MB_WORDS));
    dat = randWord();
    startCoreWrite(adr, dat);
    waitDone("core write");
    checkWriteCount("core write", 1);
    if (writeLog.size() > 0) begin
      checkIdx("core write slot", adr, writeLog[0]);
    end
    writeLog.delete();
    startWriteback('1, randBlock());
    coreWr   <= 1'b1;
    coreAdr  <= wordIdxT'(randBelow(`MB_WORDS));
    coreData <= dat;
    @(posedge clk);
    checkBit("busy under stray core write", 1'b1, busy);
    coreWr  <= 1'b0;
    wbStart <= 1'b1;
    wbData  <= randBlock();
    @(posedge clk);
    checkBit("busy under stray writeback", 1'b1, busy);
    wbStart <= 1'b0;
    waitDone("ignored starts");
    checkWriteCount("ignored starts", `MB_WORDS);

    // Slow memory with back-to-back writebacks reusing slots
    ackMaxDelay = 12;
    for (int t = 0; t < 5; t++) begin
      if (t == 2) begin
        startCoreWrite(wordIdxT'(randBelow(`MB_WORDS)), randWord());
      end
      m = (t == 0) ? '1 : wordMaskT'(randBelow(15) + 1);
      startWriteback(m, randBlock());
    end
    waitDone("back-pressure");
    repeat (4) @(posedge clk);
    checkBit("back-pressure memWrReq", 1'b0, memWrReq);
    if (expQ.size() != 0) begin
      reportProblem($sformatf("%0d expected writes never reached memory", expQ.size()));
    end

    $display("Checks %0d, value errors %0d, other errors %0d", checkCount, valueErrs, otherErrs);
    if (valueErrs == 0 && otherErrs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WatchdogNs);
    $display("Run timed out after %0d ns with tests still running", WatchdogNs);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mbx.f ====
+incdir+design
design/mbxPkg.sv
design/cacheToMbSeq.sv
design/memBuffer.sv
design/mbWriteArbiter.sv
design/mbxTop.sv
tests/tbClock.sv
tests/mbx_props.sv
tests/mbxTb.sv
